//--- Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- decode_pipereg.sv
// Single-entry register between decode and the next stage. The held item
// stays put while the next stage is busy, and a flush drops it.
`timescale 1ns/100ps

module decode_pipereg (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   in_valid,
    input  decode_pkg::s2_bundle_t in_data,
    output logic                   in_busy,
    input  logic                   flush,    // Drop the held item
    output logic                   out_valid,
    output decode_pkg::s2_bundle_t out_data,
    input  logic                   out_busy
);

    logic load;

    // Held item blocks new input, there is no skid buffer
    assign in_busy = out_valid && out_busy;
    assign load    = in_valid && !in_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0; // Beats a new input in the same cycle
        end else if (!in_busy) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

//--- decode_pkg.sv
// Shared widths, RV32 encodings, micro-op codes and payload structs of the
// decode stage. Every design file refers to these by scoped name.

package decode_pkg;

    // --------------------------------------------------
    // Widths and basic types

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [4:0]      uop_t;

    localparam reg_addr_t reg_zero = 5'd0; // Also the "no destination" index

    // --------------------------------------------------
    // Major opcodes, all ending in 2'b11 for 32-bit words

    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;

    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j,
        imm_shift  // Zero-extended shamt
    } imm_fmt_t;

    // --------------------------------------------------
    // Functional units and micro-ops

    typedef struct packed {
        logic lsu;
        logic cfu;
        logic alu;
    } fu_t;

    localparam uop_t alu_add  = 5'd1;
    localparam uop_t alu_sub  = 5'd2;
    localparam uop_t alu_and  = 5'd3;
    localparam uop_t alu_or   = 5'd4;
    localparam uop_t alu_xor  = 5'd5;
    localparam uop_t alu_slt  = 5'd6;
    localparam uop_t alu_sltu = 5'd7;
    localparam uop_t alu_sll  = 5'd8;
    localparam uop_t alu_srl  = 5'd9;
    localparam uop_t alu_sra  = 5'd10;

    localparam uop_t cfu_beq  = 5'd1;
    localparam uop_t cfu_bne  = 5'd2;
    localparam uop_t cfu_blt  = 5'd3;
    localparam uop_t cfu_bge  = 5'd4;
    localparam uop_t cfu_bltu = 5'd5;
    localparam uop_t cfu_bgeu = 5'd6;
    localparam uop_t cfu_jali = 5'd7;
    localparam uop_t cfu_jalr = 5'd8;

    // LSU micro-op is a bit field, access width sits in bits 2:1
    localparam int lsu_signed = 0;
    localparam int lsu_load   = 3;
    localparam int lsu_store  = 4;

    localparam logic [1:0] lsu_byte = 2'b01;
    localparam logic [1:0] lsu_half = 2'b10;
    localparam logic [1:0] lsu_word = 2'b11;

    // --------------------------------------------------
    // Traps and reset

    localparam reg_addr_t trap_iaccess = 5'd1; // Instruction access fault
    localparam reg_addr_t trap_iopcode = 5'd2; // Illegal instruction

    localparam word_t pc_reset_value = 32'h8000_0000;

    // --------------------------------------------------
    // Payload structs

    typedef struct packed {
        logic a_rs1;
        logic a_pcim;
        logic b_rs2;
        logic b_imm;
        logic c_rs2;
        logic c_pcim;
    } opr_src_t;

    typedef struct packed {
        fu_t       fu;
        uop_t      uop;
        reg_addr_t rd;
        logic      trap;
        imm_fmt_t  imm_fmt;
        opr_src_t  opr_src;
    } dec_ctrl_t;

    typedef struct packed {
        reg_addr_t rd;     // Destination or trap cause
        word_t     opr_a;
        word_t     opr_b;
        word_t     opr_c;
        uop_t      uop;
        fu_t       fu;
        logic      trap;
        word_t     instr;
    } s2_bundle_t;

endpackage

//--- decode_stage.sv
// Decode stage top level. Wires the decoder, immediate generator and
// operand unit into the stage register that feeds the next stage.
`timescale 1ns/100ps

module decode_stage (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   s1_valid,     // Fetch word valid
    output logic                   s1_busy,      // Stage cannot take input
    input  decode_pkg::word_t      s1_data,      // Instruction word
    input  logic                   s1_error,     // Fetch error on s1_data
    input  logic                   s1_flush,
    output decode_pkg::reg_addr_t  s1_rs1_addr,
    output decode_pkg::reg_addr_t  s1_rs2_addr,
    input  decode_pkg::word_t      s1_rs1_rdata, // Same-cycle register reads
    input  decode_pkg::word_t      s1_rs2_rdata,
    input  logic                   cf_req,
    input  decode_pkg::word_t      cf_target,
    input  logic                   cf_ack,
    output logic                   s2_valid,
    input  logic                   s2_busy,
    output decode_pkg::s2_bundle_t s2_out
);

    decode_pkg::dec_ctrl_t  ctrl;
    decode_pkg::word_t      imm;
    decode_pkg::word_t      pc_imm;
    decode_pkg::word_t      opr_a;
    decode_pkg::word_t      opr_b;
    decode_pkg::word_t      opr_c;
    decode_pkg::s2_bundle_t bundle;
    logic                   accept;

    assign accept = s1_valid && !s1_busy; // Steps the PC

    instr_decoder u_decoder (
        .instr       (s1_data),
        .fetch_error (s1_error),
        .ctrl        (ctrl),
        .rs1_addr    (s1_rs1_addr),
        .rs2_addr    (s1_rs2_addr)
    );

    imm_gen u_imm_gen (
        .instr   (s1_data),
        .imm_fmt (ctrl.imm_fmt),
        .imm     (imm),
        .pc_imm  (pc_imm)
    );

    operand_unit u_operands (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .accept    (accept),
        .cf_req    (cf_req),
        .cf_ack    (cf_ack),
        .cf_target (cf_target),
        .opr_src   (ctrl.opr_src),
        .rs1_rdata (s1_rs1_rdata),
        .rs2_rdata (s1_rs2_rdata),
        .imm       (imm),
        .pc_imm    (pc_imm),
        .opr_a     (opr_a),
        .opr_b     (opr_b),
        .opr_c     (opr_c)
    );

    assign bundle = '{
        rd:    ctrl.rd,
        opr_a: opr_a,
        opr_b: opr_b,
        opr_c: opr_c,
        uop:   ctrl.uop,
        fu:    ctrl.fu,
        trap:  ctrl.trap,
        instr: s1_data
    };

    decode_pipereg u_pipereg (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .in_valid  (s1_valid),
        .in_data   (bundle),
        .in_busy   (s1_busy),
        .flush     (s1_flush),
        .out_valid (s2_valid),
        .out_data  (s2_out),
        .out_busy  (s2_busy)
    );

endmodule

//--- imm_gen.sv
// Immediate generator for the 32-bit formats. The PC-relative formats are
// also given separately for the PC adder in the operand unit.
`timescale 1ns/100ps

module imm_gen (
    input  decode_pkg::word_t    instr,   // Instruction word
    input  decode_pkg::imm_fmt_t imm_fmt, // Format chosen by the decoder
    output decode_pkg::word_t    imm,     // Immediate for operand B
    output decode_pkg::word_t    pc_imm   // Immediate added to the PC
);

    decode_pkg::word_t imm_i;
    decode_pkg::word_t imm_s;
    decode_pkg::word_t imm_b;
    decode_pkg::word_t imm_u;
    decode_pkg::word_t imm_j;
    decode_pkg::word_t imm_sh;

    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u  = {instr[31:12], 12'b0};
    assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_sh = {27'b0, instr[24:20]}; // shamt

    always_comb begin
        case (imm_fmt)
            decode_pkg::imm_i:     imm = imm_i;
            decode_pkg::imm_s:     imm = imm_s;
            decode_pkg::imm_b:     imm = imm_b;
            decode_pkg::imm_u:     imm = imm_u;
            decode_pkg::imm_j:     imm = imm_j;
            decode_pkg::imm_shift: imm = imm_sh;
            default:               imm = '0;
        endcase
    end

    // Branch, jump and auipc offsets
    always_comb begin
        case (imm_fmt)
            decode_pkg::imm_b: pc_imm = imm_b;
            decode_pkg::imm_u: pc_imm = imm_u;
            decode_pkg::imm_j: pc_imm = imm_j;
            default:           pc_imm = '0;
        endcase
    end

endmodule

//--- instr_decoder.sv
// Combinational RV32I decoder. Recognises the supported instructions and
// gives the unit select, micro-op, destination and operand sourcing.
`timescale 1ns/100ps

module instr_decoder (
    input  decode_pkg::word_t     instr,       // Instruction word from fetch
    input  logic                  fetch_error, // Fetch flagged an access fault
    output decode_pkg::dec_ctrl_t ctrl,        // Decoded control fields
    output decode_pkg::reg_addr_t rs1_addr,
    output decode_pkg::reg_addr_t rs2_addr
);

    decode_pkg::opcode_t opcode;
    logic [2:0]          funct3;
    logic                f7_zero;
    logic                f7_alt;
    logic                legal;
    logic [1:0]          lsu_w;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign f7_zero  = instr[31:25] == 7'b0000000;
    assign f7_alt   = instr[31:25] == 7'b0100000; // sub and sra variants
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    always_comb begin
        case (funct3[1:0])
            2'b00:   lsu_w = decode_pkg::lsu_byte;
            2'b01:   lsu_w = decode_pkg::lsu_half;
            default: lsu_w = decode_pkg::lsu_word;
        endcase
    end

    always_comb begin
        ctrl    = '0;
        ctrl.rd = instr[11:7];
        legal   = 1'b1;
        // A 16-bit word never matches an opcode, low bits are always 11 here
        case (opcode)
            decode_pkg::op_lui: begin
                ctrl.fu.alu        = 1'b1;
                ctrl.uop           = decode_pkg::alu_or; // Zero OR immediate
                ctrl.imm_fmt       = decode_pkg::imm_u;
                ctrl.opr_src.b_imm = 1'b1;
            end
            decode_pkg::op_auipc: begin
                ctrl.fu.alu         = 1'b1;
                ctrl.uop            = decode_pkg::alu_add;
                ctrl.imm_fmt        = decode_pkg::imm_u;
                ctrl.opr_src.a_pcim = 1'b1;
            end
            decode_pkg::op_jal: begin
                ctrl.fu.cfu         = 1'b1;
                ctrl.uop            = decode_pkg::cfu_jali;
                ctrl.imm_fmt        = decode_pkg::imm_j;
                ctrl.opr_src.c_pcim = 1'b1; // Jump target
            end
            decode_pkg::op_jalr: begin
                ctrl.fu.cfu        = 1'b1;
                ctrl.uop           = decode_pkg::cfu_jalr;
                ctrl.imm_fmt       = decode_pkg::imm_i;
                ctrl.opr_src.a_rs1 = 1'b1;
                ctrl.opr_src.b_imm = 1'b1;
                legal              = funct3 == 3'b000;
            end
            decode_pkg::op_branch: begin
                ctrl.fu.cfu   = 1'b1;
                ctrl.imm_fmt  = decode_pkg::imm_b;
                ctrl.opr_src  = '{a_rs1: 1'b1, b_rs2: 1'b1, c_pcim: 1'b1, default: 1'b0};
                ctrl.rd       = decode_pkg::reg_zero;
                case (funct3)
                    3'b000:  ctrl.uop = decode_pkg::cfu_beq;
                    3'b001:  ctrl.uop = decode_pkg::cfu_bne;
                    3'b100:  ctrl.uop = decode_pkg::cfu_blt;
                    3'b101:  ctrl.uop = decode_pkg::cfu_bge;
                    3'b110:  ctrl.uop = decode_pkg::cfu_bltu;
                    3'b111:  ctrl.uop = decode_pkg::cfu_bgeu;
                    default: legal    = 1'b0;
                endcase
            end
            decode_pkg::op_load: begin
                ctrl.fu.lsu                      = 1'b1;
                ctrl.uop[decode_pkg::lsu_load]   = 1'b1;
                ctrl.uop[decode_pkg::lsu_signed] = !funct3[2];
                ctrl.uop[2:1]                    = lsu_w;
                ctrl.imm_fmt                     = decode_pkg::imm_i;
                ctrl.opr_src.a_rs1               = 1'b1;
                ctrl.opr_src.b_imm               = 1'b1;
                legal = funct3[1:0] != 2'b11 && funct3[2:1] != 2'b11;
            end
            decode_pkg::op_store: begin
                ctrl.fu.lsu                     = 1'b1;
                ctrl.uop[decode_pkg::lsu_store] = 1'b1;
                ctrl.uop[2:1]                   = lsu_w;
                ctrl.imm_fmt                    = decode_pkg::imm_s;
                ctrl.opr_src = '{a_rs1: 1'b1, b_imm: 1'b1, c_rs2: 1'b1, default: 1'b0};
                ctrl.rd      = decode_pkg::reg_zero;
                legal        = !funct3[2] && funct3[1:0] != 2'b11;
            end
            decode_pkg::op_imm: begin
                ctrl.fu.alu        = 1'b1;
                ctrl.imm_fmt       = decode_pkg::imm_i;
                ctrl.opr_src.a_rs1 = 1'b1;
                ctrl.opr_src.b_imm = 1'b1;
                case (funct3)
                    3'b000: ctrl.uop = decode_pkg::alu_add;
                    3'b010: ctrl.uop = decode_pkg::alu_slt;
                    3'b011: ctrl.uop = decode_pkg::alu_sltu;
                    3'b100: ctrl.uop = decode_pkg::alu_xor;
                    3'b110: ctrl.uop = decode_pkg::alu_or;
                    3'b111: ctrl.uop = decode_pkg::alu_and;
                    3'b001: begin
                        ctrl.uop     = decode_pkg::alu_sll;
                        ctrl.imm_fmt = decode_pkg::imm_shift;
                        legal        = f7_zero;
                    end
                    default: begin
                        ctrl.uop     = f7_alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
                        ctrl.imm_fmt = decode_pkg::imm_shift;
                        legal        = f7_zero || f7_alt;
                    end
                endcase
            end
            decode_pkg::op_reg: begin
                ctrl.fu.alu        = 1'b1;
                ctrl.opr_src.a_rs1 = 1'b1;
                ctrl.opr_src.b_rs2 = 1'b1;
                case (funct3)
                    3'b000:  ctrl.uop = f7_alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
                    3'b001:  ctrl.uop = decode_pkg::alu_sll;
                    3'b010:  ctrl.uop = decode_pkg::alu_slt;
                    3'b011:  ctrl.uop = decode_pkg::alu_sltu;
                    3'b100:  ctrl.uop = decode_pkg::alu_xor;
                    3'b101:  ctrl.uop = f7_alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
                    3'b110:  ctrl.uop = decode_pkg::alu_or;
                    default: ctrl.uop = decode_pkg::alu_and;
                endcase
                legal = f7_zero || (f7_alt && funct3[1:0] == 2'b00 && funct3 != 3'b100)
                        || (f7_alt && funct3 == 3'b101);
            end
            default: legal = 1'b0;
        endcase

        // Trapping words carry only the cause, illegal opcode wins
        if (!legal || fetch_error) begin
            ctrl      = '0;
            ctrl.trap = 1'b1;
            ctrl.rd   = !legal ? decode_pkg::trap_iopcode : decode_pkg::trap_iaccess;
        end
    end

endmodule

//--- operand_unit.sv
// Program counter of the decode stage and the operand multiplexers.
// Operands are an AND-OR of the sources the decoder selects.
`timescale 1ns/100ps

module operand_unit (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 accept,    // Input handshake completed
    input  logic                 cf_req,    // Control flow change request
    input  logic                 cf_ack,
    input  decode_pkg::word_t    cf_target, // New PC on a control flow change
    input  decode_pkg::opr_src_t opr_src,
    input  decode_pkg::word_t    rs1_rdata,
    input  decode_pkg::word_t    rs2_rdata,
    input  decode_pkg::word_t    imm,
    input  decode_pkg::word_t    pc_imm,
    output decode_pkg::word_t    opr_a,
    output decode_pkg::word_t    opr_b,
    output decode_pkg::word_t    opr_c
);

    decode_pkg::word_t pc;
    decode_pkg::word_t pc_plus_imm;

    // --------------------------------------------------
    // Program counter

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= decode_pkg::pc_reset_value;
        end else if (cf_req && cf_ack) begin
            pc <= cf_target; // Redirect wins over sequential step
        end else if (accept) begin
            pc <= pc + 32'd4;
        end
    end

    assign pc_plus_imm = pc + pc_imm;

    // --------------------------------------------------
    // Operand sourcing

    assign opr_a = ({decode_pkg::xlen{opr_src.a_rs1}}  & rs1_rdata) |
                   ({decode_pkg::xlen{opr_src.a_pcim}} & pc_plus_imm);

    assign opr_b = ({decode_pkg::xlen{opr_src.b_rs2}}  & rs2_rdata) |
                   ({decode_pkg::xlen{opr_src.b_imm}}  & imm);

    assign opr_c = ({decode_pkg::xlen{opr_src.c_rs2}}  & rs2_rdata) | // Store data
                   ({decode_pkg::xlen{opr_src.c_pcim}} & pc_plus_imm); // Branch target

endmodule

//--- project.f
decode_pkg.sv
instr_decoder.sv
imm_gen.sv
operand_unit.sv
decode_pipereg.sv
decode_stage.sv
tb_decode_stage_assert.sv
tb_decode_stage.sv

//--- tb_decode_stage.sv
// Testbench for the decode stage. Drives random RV32I words under random
// back-pressure, flush and redirects, and checks every bundle that leaves
// the stage against a register-file, PC and pipeline model.
`timescale 1ns/100ps

module tb_decode_stage;

    localparam int n_target   = 2000;  // Output transfers before the run ends
    localparam int max_cycles = 20000;
    localparam int max_stall  = 200;   // Cycles without an output transfer

    logic                   g_clk;
    logic                   g_resetn;
    logic                   s1_valid;
    logic                   s1_busy;
    decode_pkg::word_t      s1_data;
    logic                   s1_error;
    logic                   s1_flush;
    decode_pkg::reg_addr_t  s1_rs1_addr;
    decode_pkg::reg_addr_t  s1_rs2_addr;
    decode_pkg::word_t      s1_rs1_rdata;
    decode_pkg::word_t      s1_rs2_rdata;
    logic                   cf_req;
    decode_pkg::word_t      cf_target;
    logic                   cf_ack;
    logic                   s2_valid;
    logic                   s2_busy;
    decode_pkg::s2_bundle_t s2_out;

    decode_pkg::word_t      rf [32];     // Fixed register contents
    decode_pkg::word_t      model_pc;
    decode_pkg::s2_bundle_t cur_exp;     // Expected bundle, PC-relative part aside
    logic                   cur_a_pc;
    logic                   cur_c_pc;
    decode_pkg::word_t      cur_pcoff;
    int                     cur_kind;
    logic                   held;        // Word on s1 not yet accepted
    decode_pkg::s2_bundle_t exp_q [$];
    string                  name_q [$];
    int                     n_xfer;
    int                     stall;
    int                     cycle;
    string kind_names [11] = '{"reg", "imm", "lui", "auipc", "load", "store",
                               "branch", "jal", "jalr", "unknown", "rvc"};

    initial g_clk = 1'b0;
    always #5 g_clk = ~g_clk;

    assign s1_rs1_rdata = rf[s1_rs1_addr]; // Same-cycle register reads
    assign s1_rs2_rdata = rf[s1_rs2_addr];

    decode_stage dut0 (
        .g_clk (g_clk), .g_resetn (g_resetn),
        .s1_valid (s1_valid), .s1_busy (s1_busy), .s1_data (s1_data),
        .s1_error (s1_error), .s1_flush (s1_flush),
        .s1_rs1_addr (s1_rs1_addr), .s1_rs2_addr (s1_rs2_addr),
        .s1_rs1_rdata (s1_rs1_rdata), .s1_rs2_rdata (s1_rs2_rdata),
        .cf_req (cf_req), .cf_target (cf_target), .cf_ack (cf_ack),
        .s2_valid (s2_valid), .s2_busy (s2_busy), .s2_out (s2_out)
    );

    bind decode_stage decode_stage_assert u_assert (
        .g_clk (g_clk), .g_resetn (g_resetn), .s1_busy (s1_busy),
        .s1_flush (s1_flush), .s2_valid (s2_valid), .s2_busy (s2_busy),
        .s2_out (s2_out)
    );

    // --------------------------------------------------
    // ISA tables

    function automatic decode_pkg::uop_t alu_uop(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? decode_pkg::alu_sub : decode_pkg::alu_add;
            3'd1:    return decode_pkg::alu_sll;
            3'd2:    return decode_pkg::alu_slt;
            3'd3:    return decode_pkg::alu_sltu;
            3'd4:    return decode_pkg::alu_xor;
            3'd5:    return alt ? decode_pkg::alu_sra : decode_pkg::alu_srl;
            3'd6:    return decode_pkg::alu_or;
            default: return decode_pkg::alu_and;
        endcase
    endfunction

    function automatic decode_pkg::uop_t branch_uop(input logic [2:0] f3);
        case (f3)
            3'd0:    return decode_pkg::cfu_beq;
            3'd1:    return decode_pkg::cfu_bne;
            3'd4:    return decode_pkg::cfu_blt;
            3'd5:    return decode_pkg::cfu_bge;
            3'd6:    return decode_pkg::cfu_bltu;
            default: return decode_pkg::cfu_bgeu;
        endcase
    endfunction

    function automatic logic [1:0] lsu_width(input logic [2:0] f3);
        if (f3[1:0] == 2'd0) return decode_pkg::lsu_byte;
        if (f3[1:0] == 2'd1) return decode_pkg::lsu_half;
        return decode_pkg::lsu_word;
    endfunction

    // --------------------------------------------------
    // Stimulus and model

    // Builds a random word from chosen fields and the bundle it must give
    task automatic make_instr();
        decode_pkg::word_t     r;
        decode_pkg::word_t     sel;
        decode_pkg::reg_addr_t rd;
        decode_pkg::reg_addr_t rs1;
        decode_pkg::reg_addr_t rs2;
        logic [2:0]            f3;
        logic                  alt;
        logic [11:0]           i12;
        logic [12:0]           b13;
        logic [20:0]           j21;
        logic [19:0]           u20;
        int                    k;
        r          = $urandom;
        sel        = $urandom;
        k          = $urandom % 24;
        cur_kind   = (k < 22) ? k % 9 : k - 13; // Invalid words are rare
        rd         = r[4:0];
        rs1        = r[9:5];
        rs2        = r[14:10];
        i12        = r[26:15];
        u20        = r[31:12];
        b13        = {r[31:20], 1'b0};
        j21        = {r[31:12], 1'b0};
        f3         = sel[2:0];
        alt        = sel[3];
        s1_error   = sel[31:28] == 4'd0;
        cur_exp    = '0;
        cur_exp.rd = rd;
        cur_a_pc   = 1'b0;
        cur_c_pc   = 1'b0;
        cur_pcoff  = '0;
        case (cur_kind)
            0: begin
                alt     = alt && (f3 == 3'd0 || f3 == 3'd5);
                s1_data = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd,
                           decode_pkg::op_reg};
                cur_exp.fu.alu = 1'b1;
                cur_exp.uop    = alu_uop(f3, alt);
                cur_exp.opr_a  = rf[rs1];
                cur_exp.opr_b  = rf[rs2];
            end
            1: begin
                alt            = alt && f3 == 3'd5;
                cur_exp.fu.alu = 1'b1;
                cur_exp.uop    = alu_uop(f3, alt);
                cur_exp.opr_a  = rf[rs1];
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    s1_data = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd,
                               decode_pkg::op_imm};
                    cur_exp.opr_b = {27'b0, rs2}; // shamt
                end else begin
                    s1_data = {i12, rs1, f3, rd, decode_pkg::op_imm};
                    cur_exp.opr_b = {{20{i12[11]}}, i12};
                end
            end
            2: begin
                s1_data        = {u20, rd, decode_pkg::op_lui};
                cur_exp.fu.alu = 1'b1;
                cur_exp.uop    = decode_pkg::alu_or;
                cur_exp.opr_b  = {u20, 12'b0};
            end
            3: begin
                s1_data        = {u20, rd, decode_pkg::op_auipc};
                cur_exp.fu.alu = 1'b1;
                cur_exp.uop    = decode_pkg::alu_add;
                cur_a_pc       = 1'b1;
                cur_pcoff      = {u20, 12'b0};
            end
            4: begin
                if (f3[1:0] == 2'b11 || f3[2:1] == 2'b11) f3 = 3'b010; // Only lb to lhu
                s1_data        = {i12, rs1, f3, rd, decode_pkg::op_load};
                cur_exp.fu.lsu = 1'b1;
                cur_exp.uop[decode_pkg::lsu_load]   = 1'b1;
                cur_exp.uop[decode_pkg::lsu_signed] = !f3[2];
                cur_exp.uop[2:1] = lsu_width(f3);
                cur_exp.opr_a    = rf[rs1];
                cur_exp.opr_b    = {{20{i12[11]}}, i12};
            end
            5: begin
                f3[2] = 1'b0;
                if (f3[1:0] == 2'b11) f3 = 3'b010;
                s1_data = {i12[11:5], rs2, rs1, f3, i12[4:0], decode_pkg::op_store};
                cur_exp.fu.lsu = 1'b1;
                cur_exp.uop[decode_pkg::lsu_store] = 1'b1;
                cur_exp.uop[2:1] = lsu_width(f3);
                cur_exp.rd       = decode_pkg::reg_zero;
                cur_exp.opr_a    = rf[rs1];
                cur_exp.opr_b    = {{20{i12[11]}}, i12};
                cur_exp.opr_c    = rf[rs2]; // Store data
            end
            6: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
                s1_data = {b13[12], b13[10:5], rs2, rs1, f3, b13[4:1], b13[11],
                           decode_pkg::op_branch};
                cur_exp.fu.cfu = 1'b1;
                cur_exp.uop    = branch_uop(f3);
                cur_exp.rd     = decode_pkg::reg_zero;
                cur_exp.opr_a  = rf[rs1];
                cur_exp.opr_b  = rf[rs2];
                cur_c_pc       = 1'b1;
                cur_pcoff      = {{19{b13[12]}}, b13};
            end
            7: begin
                s1_data = {j21[20], j21[10:1], j21[11], j21[19:12], rd, decode_pkg::op_jal};
                cur_exp.fu.cfu = 1'b1;
                cur_exp.uop    = decode_pkg::cfu_jali;
                cur_c_pc       = 1'b1;
                cur_pcoff      = {{11{j21[20]}}, j21};
            end
            8: begin
                s1_data        = {i12, rs1, 3'b000, rd, decode_pkg::op_jalr};
                cur_exp.fu.cfu = 1'b1;
                cur_exp.uop    = decode_pkg::cfu_jalr;
                cur_exp.opr_a  = rf[rs1];
                cur_exp.opr_b  = {{20{i12[11]}}, i12};
            end
            9:       s1_data = {r[31:7], alt ? 7'b0001111 : 7'b1110011}; // fence, system
            default: s1_data = {r[31:2], (sel[5:4] == 2'b11) ? 2'b10 : sel[5:4]};
        endcase
        if (cur_kind >= 9 || s1_error) begin
            cur_exp      = '0;
            cur_exp.trap = 1'b1;
            cur_exp.rd   = (cur_kind >= 9) ? decode_pkg::trap_iopcode : decode_pkg::trap_iaccess;
            cur_a_pc     = 1'b0;
            cur_c_pc     = 1'b0;
        end
        cur_exp.instr = s1_data;
    endtask

    task automatic drive_inputs();
        if (!held) begin
            s1_valid = ($urandom % 4) != 0;
            if (s1_valid) make_instr();
        end
        s2_busy   = ($urandom % 3) == 0;
        s1_flush  = ($urandom % 20) == 0;
        cf_req    = ($urandom % 8) == 0;
        cf_ack    = cf_req && ($urandom % 2) == 0;
        cf_target = $urandom & 32'hffff_fffc;
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (want !== got) begin
            $display("ERR %s expected %h actual %h", name, want, got);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // Runs mid-cycle while inputs and outputs are stable, models the next edge
    task automatic check_cycle();
        decode_pkg::s2_bundle_t want;
        string                  name;
        check_value("s2_valid", {31'b0, exp_q.size() != 0}, {31'b0, s2_valid});
        check_value("s1_busy", {31'b0, exp_q.size() != 0 && s2_busy}, {31'b0, s1_busy});
        if (s2_valid && !s2_busy) begin
            want = exp_q.pop_front();
            name = name_q.pop_front();
            check_value({name, ".rd"}, {27'b0, want.rd}, {27'b0, s2_out.rd});
            check_value({name, ".opr_a"}, want.opr_a, s2_out.opr_a);
            check_value({name, ".opr_b"}, want.opr_b, s2_out.opr_b);
            check_value({name, ".opr_c"}, want.opr_c, s2_out.opr_c);
            check_value({name, ".uop"}, {27'b0, want.uop}, {27'b0, s2_out.uop});
            check_value({name, ".fu"}, {29'b0, want.fu}, {29'b0, s2_out.fu});
            check_value({name, ".trap"}, {31'b0, want.trap}, {31'b0, s2_out.trap});
            check_value({name, ".instr"}, want.instr, s2_out.instr);
            n_xfer++;
        end else if (s2_valid && s1_flush) begin
            want = exp_q.pop_front(); // Held item dropped
            name = name_q.pop_front();
        end
        held = s1_valid && s1_busy;
        if (s1_valid && !s1_busy && !s1_flush) begin
            want = cur_exp;
            if (cur_a_pc) want.opr_a = model_pc + cur_pcoff;
            if (cur_c_pc) want.opr_c = model_pc + cur_pcoff;
            exp_q.push_back(want);
            name_q.push_back(s1_error ? "fetch_error" : kind_names[cur_kind]);
        end
        if (cf_req && cf_ack) begin
            model_pc = cf_target;
        end else if (s1_valid && !s1_busy) begin
            model_pc = model_pc + 32'd4;
        end
    endtask

    // --------------------------------------------------
    // Run

    initial begin
        void'($urandom(32'hdcc3));
        g_resetn  = 1'b0;
        s1_valid  = 1'b0;
        s1_data   = '0;
        s1_error  = 1'b0;
        s1_flush  = 1'b0;
        cf_req    = 1'b0;
        cf_target = '0;
        cf_ack    = 1'b0;
        s2_busy   = 1'b0;
        held      = 1'b0;
        model_pc  = decode_pkg::pc_reset_value;
        n_xfer    = 0;
        stall     = 0;
        cycle     = 0;
        for (int i = 0; i < 32; i++) begin
            rf[i] = (i == 0) ? '0 : $urandom; // x0 reads as zero
        end
        repeat (4) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;
        while (n_xfer < n_target) begin
            drive_inputs();
            #4;
            check_cycle();
            cycle++;
            if ((s2_valid && !s2_busy) || exp_q.size() == 0) stall = 0;
            else stall++;
            if (stall > max_stall || cycle > max_cycles) begin
                $display("Timeout: %0d output transfers after %0d cycles", n_xfer, cycle);
                $display(">>> FAIL");
                $fatal(1);
            end
            @(posedge g_clk);
            #1;
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- tb_decode_stage_assert.sv
// Concurrent checks on the decode stage handshake and reset, bound into
// the DUT by the testbench.
`timescale 1ns/100ps

module decode_stage_assert (
    input logic                   g_clk,
    input logic                   g_resetn,
    input logic                   s1_busy,
    input logic                   s1_flush,
    input logic                   s2_valid,
    input logic                   s2_busy,
    input decode_pkg::s2_bundle_t s2_out
);

    // Held output under back-pressure
    held_output_stable: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        s2_valid && s2_busy |=> $stable(s2_out)
    ) else $error("s2_out changed while held under s2_busy");

    // Blocked input means the held item is still there next cycle
    held_item_kept: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        s1_busy && !s1_flush |=> s2_valid
    ) else $error("held item lost while s1_busy was high and no flush");

    no_valid_after_reset: assert property (
        @(posedge g_clk)
        !g_resetn |=> !s2_valid
    ) else $error("s2_valid high in the cycle after reset");

endmodule
